//--- bench/board_regs_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module board_regs_asserts (
    input  wire                            sysclk,
    input  wire                            reset,
    input  wire                            pwr_enable,
    input  board_regs_pkg::axis_cmd_t      axis_cmd,
    input  board_regs_pkg::axis_t          axis_enabled,
    input  board_regs_pkg::axis_t          amp_disable
);

    import board_regs_pkg::*;

    int fail_count = 0;         // failed assertion count

    // no axis turns on without a command
    enable_needs_cmd: assert property (@(posedge sysclk) disable iff (!reset)
        !axis_cmd.wr |=> ((axis_enabled & ~$past(axis_enabled)) == '0))
        else begin
            fail_count++;
            $error("axis_enabled rose to %b without an axis command", axis_enabled);
        end

    // enable request without power leaves every axis off
    cmd_unpowered: assert property (@(posedge sysclk) disable iff (!reset)
        (axis_cmd.wr && !pwr_enable) |=> (axis_enabled == '0))
        else begin
            fail_count++;
            $error("axis command with power off left axis_enabled at %b", axis_enabled);
        end

    no_unknown: assert property (@(posedge sysclk) disable iff (!reset)
        !$isunknown(amp_disable))
        else begin
            fail_count++;
            $error("amp_disable has unknown bits");
        end

endmodule

bind amp_enable_ctrl board_regs_asserts i_asserts (
    .sysclk(sysclk), .reset(reset), .pwr_enable(pwr_enable),
    .axis_cmd(axis_cmd), .axis_enabled(axis_enabled), .amp_disable(amp_disable));

`default_nettype wire

//--- bench/board_regs_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "board_regs_config.svh"

module board_regs_tb;

    import board_regs_pkg::*;

    localparam int TICK_CYCLES  = 1 << `WDOG_TICK_WIDTH;
    localparam int WD_PERIOD    = 4;    // watchdog period under test, ticks
    localparam int WD_WRITES    = 5;    // keep-alive writes, two ticks apart
    localparam int TOTAL_TICKS  = (`MV_SETTLE_TICKS + 2) + 2 * WD_WRITES + (WD_PERIOD + 2);
    localparam int LIMIT_CYCLES = (TOTAL_TICKS + 20) * TICK_CYCLES + 1000;

    logic        sysclk;
    logic        reset;
    logic [15:0] reg_waddr;
    logic [15:0] reg_raddr;
    logic [31:0] reg_wdata;
    logic        reg_wen;
    axis_t       enc_a;
    axis_t       enc_b;
    axis_t       enc_i;
    axis_t       neg_limit;
    axis_t       pos_limit;
    axis_t       home;
    axis_t       fault;
    logic        v_fault;
    logic [15:0] temp_sense;
    logic        relay;
    logic        mv_faultn;
    logic        mv_good;
    logic [3:0]  board_id;
    axis_t       safety_amp_disable;
    axis_t       amp_disable;
    logic        pwr_enable;
    logic        relay_on;
    logic        eth1394;
    logic [31:0] reg_rdata;
    logic [31:0] reg_debug;

    string cur_test;
    int    errors    = 0;
    int    checks    = 0;
    int    tests_run = 0;

    tb_clock_gen i_clk (.sysclk(sysclk), .reset(reset));

    board_regs_top i_dut (
        .sysclk(sysclk), .reset(reset),
        .reg_waddr(reg_waddr), .reg_raddr(reg_raddr),
        .reg_wdata(reg_wdata), .reg_wen(reg_wen),
        .enc_a(enc_a), .enc_b(enc_b), .enc_i(enc_i),
        .neg_limit(neg_limit), .pos_limit(pos_limit), .home(home),
        .fault(fault), .v_fault(v_fault), .temp_sense(temp_sense),
        .relay(relay), .mv_faultn(mv_faultn), .mv_good(mv_good),
        .board_id(board_id), .safety_amp_disable(safety_amp_disable),
        .amp_disable(amp_disable), .pwr_enable(pwr_enable),
        .relay_on(relay_on), .eth1394(eth1394),
        .reg_rdata(reg_rdata), .reg_debug(reg_debug));

    // ------------------------------------------------------------------------
    // bus access and compare helpers
    // ------------------------------------------------------------------------
    function automatic logic [15:0] reg_addr(input logic [3:0] offset);
        return {`ADDR_MAIN, 8'h00, offset};
    endfunction

    // returns on the accepting edge
    task automatic bus_write(input logic [15:0] addr, input logic [31:0] data);
        @(posedge sysclk);
        reg_waddr <= addr;
        reg_wdata <= data;
        reg_wen   <= 1'b1;
        @(posedge sysclk);
        reg_wen   <= 1'b0;
    endtask

    task automatic bus_read(input logic [3:0] offset, output logic [31:0] data);
        @(posedge sysclk);
        reg_raddr <= reg_addr(offset);
        @(posedge sysclk);              // rdata loads here
        @(negedge sysclk);
        data = reg_rdata;
    endtask

    task automatic wait_ticks(input int n);
        repeat (n * TICK_CYCLES) @(posedge sysclk);
    endtask

    task automatic check_word(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %s, %s: expected %h, actual %h", cur_test, what, expected, actual);
        end
    endtask

    task automatic check_axis(input string what, input axis_t expected, input axis_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %s, %s: expected %b, actual %b", cur_test, what, expected, actual);
        end
    endtask

    // bit order pwr_enable, relay_on, eth1394
    task automatic check_ctrl(input string what, input board_ctrl_t expected,
                              input board_ctrl_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %s, %s: expected %b, actual %b", cur_test, what, expected, actual);
        end
    endtask

    task automatic report_test(input int errs_start);
        tests_run++;
        if (errors == errs_start)
            $display("%s: ok", cur_test);
        else
            $display("%s: %0d errors", cur_test, errors - errs_start);
    endtask

    // ------------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------------
    task automatic readback_and_defaults();
        int          errs_start;
        logic [31:0] rd;
        logic [31:0] wr;
        logic [31:0] dbg;
        errs_start = errors;
        cur_test   = "readback_and_defaults";
        @(negedge sysclk);
        check_axis("amp_disable after reset", 4'b1111, amp_disable);
        check_ctrl("ctrl ports after reset", 3'b000, {pwr_enable, relay_on, eth1394});
        bus_read(`REG_STATUS, rd);
        check_word("status control bits", 32'h0, rd & 32'h00c5_0000);  // 23 22 18 16
        bus_read(`REG_VERSION, rd);
        check_word("version", `BOARD_VERSION, rd);
        bus_read(`REG_TIMEOUT, rd);
        check_word("timeout default", 32'h0000_ffff, rd);
        bus_read(`REG_DEBUG, rd);
        check_word("debug default", 32'h0000_2000, rd);
        check_word("debug port default", 32'h0000_2000, reg_debug);
        wr = $urandom;
        bus_write(reg_addr(`REG_PHYCTRL), wr);
        bus_read(`REG_PHYCTRL, rd);
        check_word("phyctrl", {16'h0, wr[15:0]}, rd);
        wr = $urandom;
        bus_write(reg_addr(`REG_PHYDATA), wr);
        bus_read(`REG_PHYDATA, rd);
        check_word("phydata", {16'h0, wr[15:0]}, rd);
        wr = $urandom | 32'h8000;       // long period, watchdog stays quiet
        bus_write(reg_addr(`REG_TIMEOUT), wr);
        bus_read(`REG_TIMEOUT, rd);
        check_word("timeout", {16'h0, wr[15:0]}, rd);
        dbg = $urandom;
        bus_write(reg_addr(`REG_DEBUG), dbg);
        bus_read(`REG_DEBUG, rd);
        check_word("debug", dbg, rd);
        check_word("debug port", dbg, reg_debug);
        bus_read(4'd7, rd);             // unmapped
        check_word("offset 7", 32'h0, rd);
        bus_read(4'd12, rd);
        check_word("offset 12", 32'h0, rd);
        // bits 7:4 nonzero, block must ignore it
        bus_write({`ADDR_MAIN, 4'h0, 4'h3, `REG_DEBUG}, ~dbg);
        bus_read(`REG_DEBUG, rd);
        check_word("debug after off-map write", dbg, rd);
        check_word("debug port after off-map write", dbg, reg_debug);
        report_test(errs_start);
    endtask

    task automatic input_reporting();
        int          errs_start;
        logic [31:0] rd;
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] exp_status;
        errs_start = errors;
        cur_test   = "input_reporting";
        r0 = $urandom;
        r1 = $urandom;
        @(posedge sysclk);
        enc_a      <= r0[3:0];
        enc_b      <= r0[7:4];
        enc_i      <= r0[11:8];
        neg_limit  <= r0[15:12];
        pos_limit  <= r0[19:16];
        home       <= r0[23:20];
        fault      <= r0[27:24];
        v_fault    <= r0[28];
        relay      <= r0[29];
        mv_faultn  <= r0[30];
        temp_sense <= r1[15:0];
        board_id   <= r1[19:16];
        repeat (4) @(posedge sysclk);   // two sync stages plus margin
        bus_read(`REG_DIGIN, rd);
        check_word("digin", {r0[28], 3'b000, r0[3:0], r0[7:4], r0[11:8], 4'h0,
                             r0[15:12], r0[19:16], r0[23:20]}, rd);
        bus_read(`REG_TEMPSNS, rd);
        check_word("tempsns", {16'h0, r1[15:0]}, rd);
        // power and amps still off here
        exp_status = {4'd4, r1[19:16], 4'b0000, 1'b0, 1'b0, ~r0[29], 1'b0,
                      ~r0[30], 3'b000, r0[27:24], 4'h0, 4'h0};
        bus_read(`REG_STATUS, rd);
        check_word("status", exp_status, rd);
        report_test(errs_start);
    endtask

    task automatic power_and_settle();
        int          errs_start;
        logic [31:0] rd;
        axis_t       exp_dis;
        axis_t       mask;
        axis_t       value;
        errs_start = errors;
        cur_test   = "power_and_settle";
        bus_write(reg_addr(`REG_STATUS), 32'h0000_0f0f);   // enable all, power off
        @(negedge sysclk);
        check_axis("amp_disable, power off", 4'b1111, amp_disable);
        bus_read(`REG_STATUS, rd);
        check_axis("axis enabled, power off", 4'b0000, rd[3:0]);
        bus_write(reg_addr(`REG_STATUS), 32'h00cf_0000);   // power, relay, eth1394 on
        bus_write(reg_addr(`REG_STATUS), 32'h0000_0f0f);
        bus_read(`REG_STATUS, rd);
        check_word("power relay eth bits", 32'h0045_0000, rd & 32'h0045_0000);
        check_ctrl("ctrl ports, power on", 3'b111, {pwr_enable, relay_on, eth1394});
        check_axis("axis enabled, power on", 4'b1111, rd[3:0]);
        @(posedge sysclk);
        mv_good <= 1'b1;
        wait_ticks(`MV_SETTLE_TICKS - 2);
        @(negedge sysclk);
        check_axis("amp_disable while settling", 4'b1111, amp_disable);
        wait_ticks(4);                  // settle + 2 ticks in total
        @(negedge sysclk);
        exp_dis = 4'b0000;
        check_axis("amp_disable after settle", exp_dis, amp_disable);
        repeat (4) begin
            mask  = axis_t'($urandom);
            value = axis_t'($urandom);
            for (int a = 0; a < `NUM_AXES; a++)
                if (mask[a]) exp_dis[a] = ~value[a];    // masked axes follow value
            bus_write(reg_addr(`REG_STATUS), {20'h0, mask, 4'h0, value});
            @(negedge sysclk);
            check_axis("amp_disable after masked write", exp_dis, amp_disable);
        end
        // motor voltage settled, so only the latch can hold the amps off
        bus_write(reg_addr(`REG_STATUS), 32'h0008_0000);   // power off only
        bus_write(reg_addr(`REG_STATUS), 32'h0000_0f0f);
        @(negedge sysclk);
        check_axis("amp_disable, enable after power off", 4'b1111, amp_disable);
        bus_write(reg_addr(`REG_STATUS), 32'h000c_0000);   // power back on
        report_test(errs_start);
    endtask

    task automatic watchdog_expiry();
        int          errs_start;
        logic [31:0] rd;
        errs_start = errors;
        cur_test   = "watchdog_expiry";
        bus_write(reg_addr(`REG_TIMEOUT), WD_PERIOD);
        bus_write(reg_addr(`REG_STATUS), 32'h0000_0f0f);
        for (int n = 0; n < WD_WRITES; n++) begin
            wait_ticks(2);
            bus_write(reg_addr(`REG_DEBUG), n);             // keeps the watchdog fed
        end
        bus_read(`REG_STATUS, rd);
        check_word("timeout flag while fed", 32'h0, rd & 32'h0080_0000);
        check_axis("amp_disable while fed", 4'b0000, amp_disable);
        wait_ticks(WD_PERIOD + 2);      // no writes
        bus_read(`REG_STATUS, rd);
        check_word("timeout flag after expiry", 32'h0080_0000, rd & 32'h0080_0000);
        check_axis("amp_disable after expiry", 4'b1111, amp_disable);
        bus_write(reg_addr(`REG_STATUS), 32'h000c_0000);   // power-on request clears
        bus_read(`REG_STATUS, rd);
        check_word("timeout flag after clear", 32'h0, rd & 32'h0080_0000);
        check_axis("amp_disable stays latched", 4'b1111, amp_disable);
        bus_write(reg_addr(`REG_TIMEOUT), 32'h0);           // watchdog off
        report_test(errs_start);
    endtask

    task automatic safety_input_latch();
        int          errs_start;
        logic [31:0] rd;
        axis_t       hit;
        errs_start = errors;
        cur_test   = "safety_input_latch";
        hit = axis_t'(1 << ($urandom % `NUM_AXES));
        bus_write(reg_addr(`REG_STATUS), 32'h0000_0f0f);
        @(negedge sysclk);
        check_axis("amp_disable before pulse", 4'b0000, amp_disable);
        @(posedge sysclk);
        safety_amp_disable <= hit;      // one cycle pulse
        @(posedge sysclk);
        safety_amp_disable <= '0;
        repeat (3) @(posedge sysclk);
        @(negedge sysclk);
        check_axis("amp_disable after pulse", hit, amp_disable);
        bus_read(`REG_STATUS, rd);
        check_axis("axis enabled after pulse", ~hit, rd[3:0]);
        check_axis("live safety bits", 4'b0000, rd[7:4]);
        bus_write(reg_addr(`REG_STATUS), {20'h0, hit, 4'h0, hit});
        @(negedge sysclk);
        check_axis("amp_disable after re-enable", 4'b0000, amp_disable);
        report_test(errs_start);
    endtask

    // ------------------------------------------------------------------------
    // main sequence and run limit
    // ------------------------------------------------------------------------
    initial begin
        void'($urandom(32'hfd50));
        reg_waddr          = '0;
        reg_raddr          = '0;
        reg_wdata          = '0;
        reg_wen            = 1'b0;
        enc_a              = '0;
        enc_b              = '0;
        enc_i              = '0;
        neg_limit          = '0;
        pos_limit          = '0;
        home               = '0;
        fault              = '0;
        v_fault            = 1'b0;
        temp_sense         = '0;
        relay              = 1'b0;
        mv_faultn          = 1'b1;     // no motor supply fault
        mv_good            = 1'b0;
        board_id           = '0;
        safety_amp_disable = '0;
        wait (reset === 1'b1);
        @(posedge sysclk);
        readback_and_defaults();
        input_reporting();
        power_and_settle();
        watchdog_expiry();
        safety_input_latch();
        errors += i_dut.i_amp_ctrl.i_asserts.fail_count;
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

    initial begin
        repeat (LIMIT_CYCLES) @(posedge sysclk);
        $display("run limit of %0d cycles reached before the tests finished", LIMIT_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic sysclk,
    output logic reset
);

    initial begin
        sysclk = 1'b0;
        forever #20 sysclk = ~sysclk;   // 40 ns period
    end

    // synchronous low reset, released on an edge
    initial begin
        reset = 1'b0;
        repeat (10) @(posedge sysclk);
        reset <= 1'b1;
    end

endmodule

`default_nettype wire

//--- board_regs.f
+incdir+common
common/board_regs_pkg.sv
source/input_sync.sv
source/host_reg_file.sv
supervisor/safety_supervisor.sv
source/amp_enable_ctrl.sv
source/board_regs_top.sv
bench/tb_clock_gen.sv
bench/board_regs_asserts.sv
bench/board_regs_tb.sv

//--- common/board_regs_config.svh
`ifndef BOARD_REGS_CONFIG_SVH
`define BOARD_REGS_CONFIG_SVH

// register offsets, low nibble of the host address
`define REG_STATUS      4'd0
`define REG_PHYCTRL     4'd1
`define REG_PHYDATA     4'd2
`define REG_TIMEOUT     4'd3
`define REG_VERSION     4'd4
`define REG_TEMPSNS     4'd5
`define REG_DIGIN       4'd10
`define REG_DEBUG       4'd15

`define ADDR_MAIN       4'd0            // block select in addr 15:12
`define BOARD_VERSION   32'h514C4131    // "QLA1"
`define NUM_AXES        4

`define WDOG_TICK_WIDTH 4               // 16 sysclk per tick, short for sim
`define MV_SETTLE_TICKS 24              // mv_good high time before amps on

`endif

//--- common/board_regs_pkg.sv
`default_nettype none

`include "board_regs_config.svh"

package board_regs_pkg;

    typedef logic [`NUM_AXES-1:0] axis_t;   // one bit per axis

    // raw board inputs, 45 bits
    typedef struct packed {
        axis_t       enc_a;
        axis_t       enc_b;
        axis_t       enc_i;
        axis_t       neg_limit;
        axis_t       pos_limit;
        axis_t       home;
        axis_t       fault;     // amp fault, 1 = amp ok
        logic        v_fault;   // encoder supply fault
        logic [15:0] temp_sense;
    } board_inputs_t;

    typedef struct packed {
        logic relay;            // safety relay feedback
        logic mv_faultn;        // motor supply fault, active low
        logic mv_good;          // motor voltage good
    } power_inputs_t;

    typedef struct packed {
        logic pwr_enable;
        logic relay_on;
        logic eth1394;          // 1 = ethernet-1394 mode
    } board_ctrl_t;

    // per-axis enable command from a status write
    typedef struct packed {
        logic  wr;
        axis_t mask;
        axis_t value;           // 1 = enable
    } axis_cmd_t;

    typedef struct packed {
        logic  wdog_timeout;
        axis_t wdog_disable;
        axis_t mv_disable;
    } safety_status_t;

endpackage

`default_nettype wire

//--- source/amp_enable_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module amp_enable_ctrl (
    input  wire                            sysclk,
    input  wire                            reset,
    input  wire                            pwr_enable,
    input  board_regs_pkg::axis_cmd_t      axis_cmd,
    input  board_regs_pkg::safety_status_t safety,
    input  board_regs_pkg::axis_t          safety_amp_disable,
    output board_regs_pkg::axis_t          axis_enabled,
    output board_regs_pkg::axis_t          amp_disable
);

    import board_regs_pkg::*;

    axis_t disable_q;           // latched per-axis disable, 1 = off
    axis_t cmd_disable;         // state asked for by the current command
    axis_t fault_disable;       // disables that latch in idle cycles

    // masked bits take ~value, the rest hold
    // pwr_enable here is still the value before the write
    assign cmd_disable = {$bits(axis_t){~pwr_enable}}
                       | (axis_cmd.mask & ~axis_cmd.value)
                       | (~axis_cmd.mask & disable_q);

    assign fault_disable = safety.wdog_disable | safety_amp_disable;

    always_ff @(posedge sysclk) begin
        if (!reset) begin
            disable_q <= '1;                        // all amps off
        end else if (axis_cmd.wr) begin
            disable_q <= cmd_disable;
        end else begin
            disable_q <= disable_q | fault_disable; // sticky until re-enabled
        end
    end

    // settle timer overrides without touching the latch
    assign amp_disable  = disable_q | safety.mv_disable;
    assign axis_enabled = ~disable_q;

endmodule

`default_nettype wire

//--- source/board_regs_top.sv
`timescale 1ns/1ps
`default_nettype none

module board_regs_top (
    input  wire                   sysclk,
    input  wire                   reset,
    input  wire [15:0]            reg_waddr,
    input  wire [15:0]            reg_raddr,
    input  wire [31:0]            reg_wdata,
    input  wire                   reg_wen,
    input  board_regs_pkg::axis_t enc_a,
    input  board_regs_pkg::axis_t enc_b,
    input  board_regs_pkg::axis_t enc_i,
    input  board_regs_pkg::axis_t neg_limit,
    input  board_regs_pkg::axis_t pos_limit,
    input  board_regs_pkg::axis_t home,
    input  board_regs_pkg::axis_t fault,
    input  wire                   v_fault,
    input  wire [15:0]            temp_sense,
    input  wire                   relay,
    input  wire                   mv_faultn,
    input  wire                   mv_good,
    input  wire [3:0]             board_id,         // rotary switch, static
    input  board_regs_pkg::axis_t safety_amp_disable,
    output board_regs_pkg::axis_t amp_disable,
    output logic                  pwr_enable,
    output logic                  relay_on,
    output logic                  eth1394,
    output logic [31:0]           reg_rdata,
    output logic [31:0]           reg_debug
);

    import board_regs_pkg::*;

    board_inputs_t  board_raw, board_sync;
    power_inputs_t  power_raw, power_sync;
    board_ctrl_t    ctrl;
    axis_cmd_t      axis_cmd;
    safety_status_t safety;
    axis_t          axis_enabled;
    logic [15:0]    wdog_period;
    logic           wdog_clear;

    assign board_raw = '{enc_a: enc_a, enc_b: enc_b, enc_i: enc_i,
                         neg_limit: neg_limit, pos_limit: pos_limit, home: home,
                         fault: fault, v_fault: v_fault, temp_sense: temp_sense};
    assign power_raw = '{relay: relay, mv_faultn: mv_faultn, mv_good: mv_good};

    input_sync #(.payload_t(board_inputs_t)) i_board_sync (
        .sysclk(sysclk), .reset(reset), .d(board_raw), .q(board_sync));

    input_sync #(.payload_t(power_inputs_t)) i_power_sync (
        .sysclk(sysclk), .reset(reset), .d(power_raw), .q(power_sync));

    host_reg_file i_regs (
        .sysclk(sysclk), .reset(reset),
        .reg_waddr(reg_waddr), .reg_raddr(reg_raddr),
        .reg_wdata(reg_wdata), .reg_wen(reg_wen),
        .board_id(board_id), .board_in(board_sync), .power_in(power_sync),
        .safety_amp_disable(safety_amp_disable), .safety(safety),
        .axis_enabled(axis_enabled), .ctrl(ctrl), .wdog_period(wdog_period),
        .axis_cmd(axis_cmd), .wdog_clear(wdog_clear),
        .reg_rdata(reg_rdata), .reg_debug(reg_debug));

    safety_supervisor i_supervisor (
        .sysclk(sysclk), .reset(reset), .reg_wen(reg_wen),
        .wdog_period(wdog_period), .wdog_clear(wdog_clear),
        .mv_good(power_sync.mv_good), .safety(safety));

    amp_enable_ctrl i_amp_ctrl (
        .sysclk(sysclk), .reset(reset), .pwr_enable(ctrl.pwr_enable),
        .axis_cmd(axis_cmd), .safety(safety),
        .safety_amp_disable(safety_amp_disable),
        .axis_enabled(axis_enabled), .amp_disable(amp_disable));

    assign pwr_enable = ctrl.pwr_enable;
    assign relay_on   = ctrl.relay_on;
    assign eth1394    = ctrl.eth1394;

endmodule

`default_nettype wire

//--- source/host_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "board_regs_config.svh"

module host_reg_file (
    input  wire                            sysclk,
    input  wire                            reset,
    input  wire [15:0]                     reg_waddr,
    input  wire [15:0]                     reg_raddr,
    input  wire [31:0]                     reg_wdata,
    input  wire                            reg_wen,
    input  wire [3:0]                      board_id,
    input  board_regs_pkg::board_inputs_t  board_in,
    input  board_regs_pkg::power_inputs_t  power_in,
    input  board_regs_pkg::axis_t          safety_amp_disable,
    input  board_regs_pkg::safety_status_t safety,
    input  board_regs_pkg::axis_t          axis_enabled,
    output board_regs_pkg::board_ctrl_t    ctrl,
    output logic [15:0]                    wdog_period,
    output board_regs_pkg::axis_cmd_t      axis_cmd,
    output logic                           wdog_clear,
    output logic [31:0]                    reg_rdata,
    output logic [31:0]                    reg_debug
);

    import board_regs_pkg::*;

    logic        wr_hit;        // write addressed to this block
    logic        wr_status;
    logic [15:0] phy_ctrl;      // phy request bitstream
    logic [15:0] phy_data;      // phy register transfer data
    board_ctrl_t ctrl_next;

    assign wr_hit    = reg_wen && (reg_waddr[15:12] == `ADDR_MAIN) && (reg_waddr[7:4] == 4'd0);
    assign wr_status = wr_hit && (reg_waddr[3:0] == `REG_STATUS);

    // axis enables use mask 11:8 over value 3:0
    assign axis_cmd.wr    = wr_status;
    assign axis_cmd.mask  = reg_wdata[11:8];
    assign axis_cmd.value = reg_wdata[3:0];

    assign wdog_clear = wr_status && reg_wdata[19] && reg_wdata[18];   // power-on request

    // ------------------------------------------------------------------------
    // masked control bits of a status write
    // ------------------------------------------------------------------------
    always_comb begin
        ctrl_next = ctrl;
        if (reg_wdata[19]) ctrl_next.pwr_enable = reg_wdata[18];
        if (reg_wdata[17]) ctrl_next.relay_on   = reg_wdata[16];
        if (reg_wdata[23]) ctrl_next.eth1394    = reg_wdata[22];
    end

    always_ff @(posedge sysclk) begin
        if (!reset) begin
            ctrl        <= '0;          // power, relay off
            phy_ctrl    <= '0;
            phy_data    <= '0;
            wdog_period <= 16'hffff;    // long period until host sets one
            reg_debug   <= 32'h2000;
            reg_rdata   <= '0;
        end else begin
            if (wr_hit) begin
                case (reg_waddr[3:0])
                    `REG_STATUS:  ctrl        <= ctrl_next;
                    `REG_PHYCTRL: phy_ctrl    <= reg_wdata[15:0];
                    `REG_PHYDATA: phy_data    <= reg_wdata[15:0];
                    `REG_TIMEOUT: wdog_period <= reg_wdata[15:0];
                    `REG_DEBUG:   reg_debug   <= reg_wdata;
                    default: ;                  // read-only or unmapped
                endcase
            end

            // read port runs whenever the bus is not writing
            if (!reg_wen) begin
                case (reg_raddr[3:0])
                    `REG_STATUS: reg_rdata <= {
                        4'd4, board_id,                         // channels, id
                        safety.wdog_timeout, ctrl.eth1394, 2'b00,
                        power_in.mv_good, ctrl.pwr_enable,
                        ~power_in.relay, ctrl.relay_on,
                        ~power_in.mv_faultn, 3'b000,
                        board_in.fault,
                        safety_amp_disable, axis_enabled};
                    `REG_PHYCTRL: reg_rdata <= {16'd0, phy_ctrl};
                    `REG_PHYDATA: reg_rdata <= {16'd0, phy_data};
                    `REG_TIMEOUT: reg_rdata <= {16'd0, wdog_period};
                    `REG_VERSION: reg_rdata <= `BOARD_VERSION;
                    `REG_TEMPSNS: reg_rdata <= {16'd0, board_in.temp_sense};
                    `REG_DIGIN: reg_rdata <= {
                        board_in.v_fault, 3'b000,
                        board_in.enc_a, board_in.enc_b, board_in.enc_i,
                        4'b0000,                                // DOUT slot, not implemented
                        board_in.neg_limit, board_in.pos_limit, board_in.home};
                    `REG_DEBUG: reg_rdata <= reg_debug;
                    default:    reg_rdata <= '0;        // unmapped reads 0
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- source/input_sync.sv
`timescale 1ns/1ps
`default_nettype none

// two flop synchronizer, one instance per input bundle
module input_sync #(
    parameter type payload_t = logic
) (
    input  wire      sysclk,
    input  wire      reset,
    input  payload_t d,
    output payload_t q
);

    payload_t meta;             // first stage, may go metastable

    always_ff @(posedge sysclk) begin
        if (!reset) begin
            meta <= '0;
            q    <= '0;
        end else begin
            meta <= d;
            q    <= meta;       // settled copy
        end
    end

endmodule

`default_nettype wire

//--- supervisor/safety_supervisor.sv
`timescale 1ns/1ps
`default_nettype none

`include "board_regs_config.svh"

module safety_supervisor (
    input  wire                            sysclk,
    input  wire                            reset,
    input  wire                            reg_wen,
    input  wire [15:0]                     wdog_period,
    input  wire                            wdog_clear,
    input  wire                            mv_good,
    output board_regs_pkg::safety_status_t safety
);

    import board_regs_pkg::*;

    localparam int SETTLE_W = $clog2(`MV_SETTLE_TICKS + 1);
    localparam logic [SETTLE_W-1:0] SETTLE_DONE = SETTLE_W'(`MV_SETTLE_TICKS);

    logic [`WDOG_TICK_WIDTH-1:0] presc;
    logic                        tick;          // one sysclk wide
    logic [15:0]                 wdog_count;
    logic                        wdog_timeout;
    axis_t                       wdog_dis;
    logic [SETTLE_W-1:0]         settle_count;
    axis_t                       mv_dis;

    // ------------------------------------------------------------------------
    // tick prescaler
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!reset) presc <= '0;
        else        presc <= presc + 1'b1;  // free running
    end

    assign tick = &presc;

    // ------------------------------------------------------------------------
    // watchdog, restarted by any host write
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            wdog_count   <= '0;
            wdog_timeout <= 1'b0;
            wdog_dis     <= '0;
        end else begin
            if (reg_wen) begin
                wdog_count <= '0;
                wdog_dis   <= '0;           // amp_enable_ctrl keeps its own latch
            end else if (tick && (wdog_period != 16'd0)) begin   // period 0 = off
                if (wdog_count < wdog_period) begin
                    wdog_count <= wdog_count + 1'b1;
                end else begin
                    wdog_timeout <= 1'b1;
                    wdog_dis     <= '1;
                end
            end
            if (wdog_clear) wdog_timeout <= 1'b0;   // host powering back on
        end
    end

    // ------------------------------------------------------------------------
    // motor voltage settle timer
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            settle_count <= '0;
            mv_dis       <= '1;
        end else if (!mv_good) begin
            settle_count <= '0;             // restart on any dropout
            mv_dis       <= '1;
        end else if (tick && (settle_count != SETTLE_DONE)) begin
            settle_count <= settle_count + 1'b1;
            if (settle_count == SETTLE_DONE - 1'b1) mv_dis <= '0;   // last tick
        end
    end

    assign safety.wdog_timeout = wdog_timeout;
    assign safety.wdog_disable = wdog_dis;
    assign safety.mv_disable   = mv_dis;

endmodule

`default_nettype wire
